// File: rtl/ipu_pkg.sv
// Fixed 32-bit datapath where the spare SEW encoding is decoded as 32-bit elements
package ipu_pkg;

    // Datapath width in bits and bytes
    localparam int unsigned ELEN  = 32;
    localparam int unsigned ELENB = ELEN / 8;

    typedef logic [ELEN-1:0] elen_t;

    // Selected element width
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_e;

    // Operation as requested by the issuing core
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_MINU = 4'd5,
        OP_MIN  = 4'd6,
        OP_MAXU = 4'd7,
        OP_MAX  = 4'd8
    } op_e;

    // Operation as seen by a lane with signedness carried separately
    typedef enum logic [2:0] {
        LANE_ADD = 3'd0,
        LANE_SUB = 3'd1,
        LANE_AND = 3'd2,
        LANE_OR  = 3'd3,
        LANE_XOR = 3'd4,
        LANE_MIN = 3'd5,
        LANE_MAX = 3'd6
    } lane_op_e;

    // One datapath word split into bytes, halfwords or kept whole
    typedef union packed {
        logic [ELENB-1:0][7:0]    b;
        logic [ELEN/16-1:0][15:0] h;
        elen_t                    w;
    } lane_word_u;

endpackage

// File: rtl/ipu_decode.sv
// Purely combinational and relies on the operands staying stable while valid is high
`timescale 1ns/100ps
module ipu_decode import ipu_pkg::*; (
    input  op_e        operation_i,
    input  sew_e       sew_i,
    input  elen_t      op_s1_i,
    input  elen_t      op_s2_i,
    input  logic       operation_valid_i,
    output lane_op_e   lane_op_o,
    output logic       lane_signed_o,
    output logic [3:0] lane_valid_o,
    output logic [7:0] s1_b0_o,
    output logic [7:0] s1_b1_o,
    output logic [7:0] s2_b0_o,
    output logic [7:0] s2_b1_o,
    output logic [15:0] s1_h_o,
    output logic [15:0] s2_h_o,
    output elen_t      s1_w_o,
    output elen_t      s2_w_o
);

    lane_word_u s1_u;
    lane_word_u s2_u;
    logic       is_signed;

    assign s1_u = op_s1_i;
    assign s2_u = op_s2_i;

    // Only the signed compares extend with the sign bit
    assign is_signed     = operation_i inside {OP_MIN, OP_MAX};
    assign lane_signed_o = is_signed;

    ////////////////////////////////////////////////////////////
    // Operation folding
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (operation_i)
            OP_ADD:          lane_op_o = LANE_ADD;
            OP_SUB:          lane_op_o = LANE_SUB;
            OP_AND:          lane_op_o = LANE_AND;
            OP_OR:           lane_op_o = LANE_OR;
            OP_XOR:          lane_op_o = LANE_XOR;
            OP_MINU, OP_MIN: lane_op_o = LANE_MIN;
            OP_MAXU, OP_MAX: lane_op_o = LANE_MAX;
            default:         lane_op_o = LANE_ADD;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Operand distribution
    ////////////////////////////////////////////////////////////

    always_comb begin
        s1_b0_o      = '0;
        s1_b1_o      = '0;
        s2_b0_o      = '0;
        s2_b1_o      = '0;
        s1_h_o       = '0;
        s2_h_o       = '0;
        s1_w_o       = '0;
        s2_w_o       = '0;
        lane_valid_o = '0;
        case (sew_i)
            SEW_8: begin
                s1_b0_o      = s1_u.b[0];
                s1_b1_o      = s1_u.b[1];
                s2_b0_o      = s2_u.b[0];
                s2_b1_o      = s2_u.b[1];
                // Upper bytes ride in the wider lanes
                s1_h_o       = {{8{is_signed & s1_u.b[2][7]}}, s1_u.b[2]};
                s2_h_o       = {{8{is_signed & s2_u.b[2][7]}}, s2_u.b[2]};
                s1_w_o       = {{(ELEN-8){is_signed & s1_u.b[3][7]}}, s1_u.b[3]};
                s2_w_o       = {{(ELEN-8){is_signed & s2_u.b[3][7]}}, s2_u.b[3]};
                lane_valid_o = {4{operation_valid_i}};
            end
            SEW_16: begin
                s1_h_o       = s1_u.h[0];
                s2_h_o       = s2_u.h[0];
                s1_w_o       = {{(ELEN-16){is_signed & s1_u.h[1][15]}}, s1_u.h[1]};
                s2_w_o       = {{(ELEN-16){is_signed & s2_u.h[1][15]}}, s2_u.h[1]};
                lane_valid_o = {{2{operation_valid_i}}, 2'b00};
            end
            default: begin
                s1_w_o       = s1_u.w;
                s2_w_o       = s2_u.w;
                lane_valid_o = {operation_valid_i, 3'b000};
            end
        endcase
    end

endmodule

// File: rtl/ipu_lane.sv
// Combinational lane ALU with no carry in or out and a zero result while not valid
`timescale 1ns/100ps
module ipu_lane import ipu_pkg::*; #(
    parameter int unsigned Width = 32
) (
    input  lane_op_e         op_i,
    input  logic             signed_i,
    input  logic             valid_i,
    input  logic [Width-1:0] s1_i,
    input  logic [Width-1:0] s2_i,
    output logic [Width-1:0] result_o
);

    logic             s1_less;
    logic [Width-1:0] alu_res;

    // One comparator serves both min and max
    assign s1_less = signed_i ? ($signed(s1_i) < $signed(s2_i)) : (s1_i < s2_i);

    always_comb begin
        case (op_i)
            LANE_ADD: alu_res = s1_i + s2_i;
            LANE_SUB: alu_res = s1_i - s2_i;
            LANE_AND: alu_res = s1_i & s2_i;
            LANE_OR:  alu_res = s1_i | s2_i;
            LANE_XOR: alu_res = s1_i ^ s2_i;
            LANE_MIN: alu_res = s1_less ? s1_i : s2_i;
            LANE_MAX: alu_res = s1_less ? s2_i : s1_i;
            default:  alu_res = '0;
        endcase
    end

    // Idle lanes drive zero
    assign result_o = valid_i ? alu_res : '0;

endmodule

// File: rtl/ipu_result.sv
// Single output register so one result is held while the next one is computed
`timescale 1ns/100ps
module ipu_result import ipu_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  sew_e        sew_i,
    input  logic        operation_valid_i,
    input  logic [7:0]  res_b0_i,
    input  logic [7:0]  res_b1_i,
    input  logic [15:0] res_h_i,
    input  elen_t       res_w_i,
    input  logic        result_ready_i,
    output logic        operation_ready_o,
    output logic        result_valid_o,
    output elen_t       result_o
);

    lane_word_u collect_word;
    elen_t      result_q;
    logic       result_valid_q;
    logic       load;

    ////////////////////////////////////////////////////////////
    // Collector
    ////////////////////////////////////////////////////////////

    always_comb begin
        collect_word.w = res_w_i;
        case (sew_i)
            SEW_8: begin
                collect_word.b[0] = res_b0_i;
                collect_word.b[1] = res_b1_i;
                collect_word.b[2] = res_h_i[7:0];
                collect_word.b[3] = res_w_i[7:0];
            end
            SEW_16: begin
                collect_word.h[0] = res_h_i;
                collect_word.h[1] = res_w_i[15:0];
            end
            default: begin
                collect_word.w = res_w_i;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    // Free when empty or drained this cycle
    assign operation_ready_o = ~result_valid_q | result_ready_i;
    assign load              = operation_valid_i & operation_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_valid_q <= 1'b0;
        end else if (operation_ready_o) begin
            result_valid_q <= operation_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            result_q <= collect_word.w;
        end
    end

    assign result_o       = result_q;
    assign result_valid_o = result_valid_q;

endmodule

// File: rtl/ipu_top.sv
// No multiply or divide, and all lanes run the same operation in each cycle
`timescale 1ns/100ps
module ipu_top import ipu_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  op_e   operation_i,
    input  sew_e  sew_i,
    input  elen_t op_s1_i,
    input  elen_t op_s2_i,
    input  logic  operation_valid_i,
    output logic  operation_ready_o,
    output elen_t result_o,
    output logic  result_valid_o,
    input  logic  result_ready_i
);

    lane_op_e    lane_op;
    logic        lane_signed;
    logic [3:0]  lane_valid;
    logic [7:0]  s1_b0;
    logic [7:0]  s1_b1;
    logic [7:0]  s2_b0;
    logic [7:0]  s2_b1;
    logic [15:0] s1_h;
    logic [15:0] s2_h;
    elen_t       s1_w;
    elen_t       s2_w;
    logic [7:0]  res_b0;
    logic [7:0]  res_b1;
    logic [15:0] res_h;
    elen_t       res_w;

    ipu_decode i_decode (
        .operation_i       (operation_i),
        .sew_i             (sew_i),
        .op_s1_i           (op_s1_i),
        .op_s2_i           (op_s2_i),
        .operation_valid_i (operation_valid_i),
        .lane_op_o         (lane_op),
        .lane_signed_o     (lane_signed),
        .lane_valid_o      (lane_valid),
        .s1_b0_o           (s1_b0),
        .s1_b1_o           (s1_b1),
        .s2_b0_o           (s2_b0),
        .s2_b1_o           (s2_b1),
        .s1_h_o            (s1_h),
        .s2_h_o            (s2_h),
        .s1_w_o            (s1_w),
        .s2_w_o            (s2_w)
    );

    ////////////////////////////////////////////////////////////
    // SIMD lanes
    ////////////////////////////////////////////////////////////

    ipu_lane #(.Width(8)) i_lane_8b_0 (
        .op_i     (lane_op),
        .signed_i (lane_signed),
        .valid_i  (lane_valid[0]),
        .s1_i     (s1_b0),
        .s2_i     (s2_b0),
        .result_o (res_b0)
    );

    ipu_lane #(.Width(8)) i_lane_8b_1 (
        .op_i     (lane_op),
        .signed_i (lane_signed),
        .valid_i  (lane_valid[1]),
        .s1_i     (s1_b1),
        .s2_i     (s2_b1),
        .result_o (res_b1)
    );

    ipu_lane #(.Width(16)) i_lane_16b_0 (
        .op_i     (lane_op),
        .signed_i (lane_signed),
        .valid_i  (lane_valid[2]),
        .s1_i     (s1_h),
        .s2_i     (s2_h),
        .result_o (res_h)
    );

    ipu_lane #(.Width(ELEN)) i_lane_32b_0 (
        .op_i     (lane_op),
        .signed_i (lane_signed),
        .valid_i  (lane_valid[3]),
        .s1_i     (s1_w),
        .s2_i     (s2_w),
        .result_o (res_w)
    );

    ipu_result i_result (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .sew_i             (sew_i),
        .operation_valid_i (operation_valid_i),
        .res_b0_i          (res_b0),
        .res_b1_i          (res_b1),
        .res_h_i           (res_h),
        .res_w_i           (res_w),
        .result_ready_i    (result_ready_i),
        .operation_ready_o (operation_ready_o),
        .result_valid_o    (result_valid_o),
        .result_o          (result_o)
    );

endmodule

// File: bench/ipu_tb.sv
// Directed and random tests of the IPU, which stop at the first mismatch and keep results in order
`timescale 1ns/100ps
module ipu_tb import ipu_pkg::*;;

    localparam int unsigned CLK_PERIOD      = 10;
    localparam int unsigned RESET_CYCLES    = 10;
    localparam int unsigned DIRECTED_OPS    = 40;
    localparam int unsigned RAND_OPS        = 200;
    localparam int unsigned WATCHDOG_CYCLES = (DIRECTED_OPS + RAND_OPS) * 20 + RESET_CYCLES;
    localparam logic [31:0] SEED            = 32'haf7d3bf3;

    logic  clk_i;
    logic  rst_n_i;
    op_e   operation_i;
    sew_e  sew_i;
    elen_t op_s1_i;
    elen_t op_s2_i;
    logic  operation_valid_i;
    logic  operation_ready_o;
    elen_t result_o;
    logic  result_valid_o;
    logic  result_ready_i;

    elen_t       expected_q[$];
    int unsigned consumed_count;

    ipu_top uut (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .operation_i       (operation_i),
        .sew_i             (sew_i),
        .op_s1_i           (op_s1_i),
        .op_s2_i           (op_s2_i),
        .operation_valid_i (operation_valid_i),
        .operation_ready_o (operation_ready_o),
        .result_o          (result_o),
        .result_valid_o    (result_valid_o),
        .result_ready_i    (result_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired with %0d results still pending", expected_q.size());
        $display("Result: FAILED");
        $fatal(1, "Simulation did not finish in time");
    end

    ////////////////////////////////////////////////////////////
    // Reference model and checking
    ////////////////////////////////////////////////////////////

    // Element by element with each wrapping at its own width
    function automatic elen_t model(input op_e op, input sew_e sew, input elen_t a, input elen_t b);
        int unsigned ew;
        logic [31:0] mask;
        logic [31:0] flip;
        logic [31:0] ea;
        logic [31:0] eb;
        logic [31:0] er;
        logic        lt;
        elen_t       res;
        ew   = (sew == SEW_8) ? 8 : ((sew == SEW_16) ? 16 : 32);
        mask = (ew == 32) ? 32'hffff_ffff : ((32'd1 << ew) - 32'd1);
        // Offsetting the sign bit turns a signed compare into an unsigned one
        flip = (op == OP_MIN || op == OP_MAX) ? (32'd1 << (ew - 1)) : 32'd0;
        res  = '0;
        for (int unsigned i = 0; i < 32; i += ew) begin
            ea = (a >> i) & mask;
            eb = (b >> i) & mask;
            lt = (ea ^ flip) < (eb ^ flip);
            case (op)
                OP_ADD:          er = ea + eb;
                OP_SUB:          er = ea - eb;
                OP_AND:          er = ea & eb;
                OP_OR:           er = ea | eb;
                OP_XOR:          er = ea ^ eb;
                OP_MIN, OP_MINU: er = lt ? ea : eb;
                default:         er = lt ? eb : ea;
            endcase
            res = res | ((er & mask) << i);
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %0t %s expected %08h actual %08h", $time, name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Every consumed result is checked in order
    always @(negedge clk_i) begin
        if (rst_n_i && result_valid_o && result_ready_i) begin
            if (expected_q.size() == 0) begin
                $display("A result was consumed with no operation outstanding");
                $display("Result: FAILED");
                $fatal(1, "Unexpected result");
            end else begin
                check_value("result_o", expected_q.pop_front(), result_o);
                consumed_count++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Driving
    ////////////////////////////////////////////////////////////

    // Called at 1 ns after an edge and returns 1 ns after the accepting edge
    task automatic send_op(input op_e op, input sew_e sew, input elen_t a, input elen_t b);
        operation_i       = op;
        sew_i             = sew;
        op_s1_i           = a;
        op_s2_i           = b;
        operation_valid_i = 1'b1;
        expected_q.push_back(model(op, sew, a, b));
        @(negedge clk_i);
        while (!operation_ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        operation_valid_i = 1'b0;
    endtask

    task automatic send_timed(input op_e op, input sew_e sew, input elen_t a, input elen_t b);
        send_op(op, sew, a, b);
        check_value("result_valid_o", 32'd1, 32'(result_valid_o));
        check_value("result_o", model(op, sew, a, b), result_o);
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic reset_state();
        check_value("result_valid_o", 32'd0, 32'(result_valid_o));
        check_value("operation_ready_o", 32'd1, 32'(operation_ready_o));
    endtask

    task automatic word_arith();
        send_timed(OP_ADD, SEW_32, 32'hffff_ffff, 32'h0000_0001);
        send_timed(OP_ADD, SEW_32, 32'h7fff_ffff, 32'h0000_0001);
        send_timed(OP_ADD, SEW_32, 32'h8000_0000, 32'h8000_0000);
        send_timed(OP_SUB, SEW_32, 32'h0000_0000, 32'h0000_0001);
        send_timed(OP_SUB, SEW_32, 32'h8000_0000, 32'h0000_0001);
        send_timed(OP_SUB, SEW_32, 32'h1234_5678, 32'h8765_4321);
    endtask

    // Every element overflows or borrows
    task automatic element_isolation();
        send_timed(OP_ADD, SEW_8, 32'h80ff_7fff, 32'h8001_7f01);
        send_timed(OP_ADD, SEW_8, 32'hffff_ffff, 32'h0101_0101);
        send_timed(OP_SUB, SEW_8, 32'h0000_0000, 32'h0101_0101);
        send_timed(OP_ADD, SEW_16, 32'hffff_8000, 32'h0001_8000);
        send_timed(OP_ADD, SEW_16, 32'hffff_ffff, 32'h0001_0001);
        send_timed(OP_SUB, SEW_16, 32'h0000_0000, 32'h0001_0001);
    endtask

    task automatic signedness();
        op_e   ops [4] = '{OP_MIN, OP_MINU, OP_MAX, OP_MAXU};
        sew_e  sews [3] = '{SEW_8, SEW_16, SEW_32};
        elen_t a = 32'h80ff_7f01;
        elen_t b = 32'h7f01_80ff;
        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 4; o++) begin
                send_timed(ops[o], sews[s], a, b);
                send_timed(ops[o], sews[s], b, a);
            end
        end
    endtask

    task automatic back_pressure();
        elen_t held;
        wait_drain();
        result_ready_i = 1'b0;
        send_op(OP_XOR, SEW_32, 32'ha5a5_a5a5, 32'h0ff0_0ff0);
        held = result_o;
        check_value("result_o", model(OP_XOR, SEW_32, 32'ha5a5_a5a5, 32'h0ff0_0ff0), held);
        // Second operation waits while the first is held
        operation_i       = OP_MAXU;
        sew_i             = SEW_8;
        op_s1_i           = 32'h12ab_34cd;
        op_s2_i           = 32'h90ef_0102;
        operation_valid_i = 1'b1;
        expected_q.push_back(model(OP_MAXU, SEW_8, 32'h12ab_34cd, 32'h90ef_0102));
        repeat (5) begin
            @(posedge clk_i);
            #1;
            check_value("result_valid_o", 32'd1, 32'(result_valid_o));
            check_value("result_o", held, result_o);
            check_value("operation_ready_o", 32'd0, 32'(operation_ready_o));
        end
        result_ready_i = 1'b1;
        #1;
        check_value("operation_ready_o", 32'd1, 32'(operation_ready_o));
        @(posedge clk_i);
        #1;
        operation_valid_i = 1'b0;
        check_value("result_valid_o", 32'd1, 32'(result_valid_o));
        check_value("result_o", model(OP_MAXU, SEW_8, 32'h12ab_34cd, 32'h90ef_0102), result_o);
        wait_drain();
    endtask

    task automatic random_traffic();
        int unsigned start_count;
        int unsigned gap;
        bit          sending;
        start_count = consumed_count;
        sending     = 1'b1;
        fork
            begin
                for (int n = 0; n < RAND_OPS; n++) begin
                    send_op(op_e'($urandom_range(0, 8)), sew_e'($urandom_range(0, 3)),
                            $urandom(), $urandom());
                    gap = $urandom_range(0, 2);
                    repeat (gap) begin
                        @(posedge clk_i);
                        #1;
                    end
                end
                sending = 1'b0;
            end
            begin
                while (sending) begin
                    @(posedge clk_i);
                    #1;
                    result_ready_i = ($urandom_range(0, 1) == 1);
                end
            end
        join
        // A held result drains on the next edge once the sink is ready
        result_ready_i = 1'b1;
        @(posedge clk_i);
        #1;
        check_value("random result count", RAND_OPS, consumed_count - start_count);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n_i           = 1'b0;
        operation_i       = OP_ADD;
        sew_i             = SEW_32;
        op_s1_i           = '0;
        op_s2_i           = '0;
        operation_valid_i = 1'b0;
        result_ready_i    = 1'b1;
        consumed_count    = 0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        reset_state();
        word_arith();
        element_isolation();
        signedness();
        back_pressure();
        random_traffic();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: sim.f
rtl/ipu_pkg.sv
rtl/ipu_decode.sv
rtl/ipu_lane.sv
rtl/ipu_result.sv
rtl/ipu_top.sv
bench/ipu_tb.sv

// File: Makefile
# Verilator build and run of the IPU testbench

VERILATOR ?= verilator
TOP       ?= ipu_tb
RTL_TOP   ?= ipu_top
BUILD_DIR ?= build
FILELIST  ?= sim.f
VFLAGS    ?= --binary -j 0

RTL_SRCS = rtl/ipu_pkg.sv \
           rtl/ipu_decode.sv \
           rtl/ipu_lane.sv \
           rtl/ipu_result.sv \
           rtl/ipu_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the testbench reports it
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "Result: PASSED"

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
